//--- flist.f
+incdir+sim
src/geom_pkg.sv
src/scene_pkg.sv
src/scene_ram.sv
src/frame_driver.sv
src/vertex_xform.sv
src/tri_assembler.sv
src/render_front.sv
sim/tb_render_front.sv

//--- run_sim.sh
#!/bin/sh
# build and run the render front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f flist.f --top-module tb_render_front; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_render_front)
status=$?
echo "$out"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "Simulation PASSED"; then
    exit 0
fi
exit 1

//--- sim/tb_tests.svh
task automatic host_write(input table_sel_t tbl, input int addr, input logic [127:0] data);
    @(negedge clk);
    scene_wr = '{we: 1'b1, sel: tbl, addr: 13'(addr), data: data};
    @(negedge clk);
    scene_wr.we = 1'b0;
endtask

function automatic transform_t make_xf(input logic [7:0] s, input logic [15:0] tx,
                                       input logic [15:0] ty, input logic [15:0] tz);
    transform_t t;
    t.scale = s;
    t.tx    = tx;
    t.ty    = ty;
    t.tz    = tz;
    return t;
endfunction

function automatic inst_desc_t make_inst(input int vbase, input int tbase, input int cnt,
                                         input transform_t xf, input logic [11:0] color);
    inst_desc_t d;
    d.vert_base = 13'(vbase);
    d.tri_base  = 13'(tbase);
    d.tri_count = 8'(cnt);
    d.xf        = xf;
    d.color     = color;
    return d;
endfunction

function automatic vertex_t make_vert(input logic [15:0] x, input logic [15:0] y,
                                      input logic [15:0] z, input logic [11:0] c);
    vertex_t v;
    v.x     = x;
    v.y     = y;
    v.z     = z;
    v.color = c;
    return v;
endfunction

task automatic put_inst(input int a, input inst_desc_t d);
    inst_m[a] = d;
    host_write(TBL_INST, a, 128'(d));
endtask

task automatic put_tri(input int a, input int i0, input int i1, input int i2);
    tri_m[a] = '{i0: 8'(i0), i1: 8'(i1), i2: 8'(i2)};
    host_write(TBL_TRI, a, 128'(tri_m[a]));
endtask

task automatic put_vert(input int a, input vertex_t v);
    vert_m[a] = v;
    host_write(TBL_VERT, a, 128'(v));
endtask

// start a frame, optionally pulse frame_start again mid frame, compare results
task automatic run_frame(input logic [7:0] n, input int restart_at);
    int cyc;
    int done_before;
    int n_at_done;
    build_expected(n);
    got_q.delete();
    done_before = done_cnt;
    @(negedge clk);
    num_inst    = n;
    frame_start = 1'b1;
    @(negedge clk);
    frame_start = 1'b0;
    assert (busy) else begin
        $display("busy did not rise after frame_start");
        stop_on_error();
    end
    cyc = 0;
    while (frame_done !== 1'b1) begin
        if (cyc == restart_at) begin
            check_eq("busy", 180'(busy), 180'(1));
            frame_start = 1'b1;
        end
        @(negedge clk);
        frame_start = 1'b0;
        cyc++;
        if (cyc == 2) begin
            check_eq("bg_color", 180'(bg_color), 180'(inst_m[0].color));
        end
        assert (cyc < FRAME_LIMIT) else begin
            $display("frame_done did not arrive within %0d cycles", FRAME_LIMIT);
            stop_on_error();
        end
    end
    check_eq("busy", 180'(busy), 180'(0));
    n_at_done = got_q.size();
    repeat (8) @(negedge clk);
    check_eq("frame_done count", 180'(done_cnt - done_before), 180'(1));
    check_eq("tri_valid count after frame_done", 180'(got_q.size()), 180'(n_at_done));
    check_eq("tri_valid count", 180'(got_q.size()), 180'(exp_q.size()));
    foreach (exp_q[i]) begin
        check_eq("tri_out", got_q[i], exp_q[i]);
    end
endtask

task automatic unity_passthrough();
    put_inst(0, make_inst(0, 0, 0, make_xf(8'h00, 16'd0, 16'd0, 16'd0), 12'h123));
    put_inst(1, make_inst(0, 0, 1, make_xf(8'h10, 16'd0, 16'd0, 16'd0), 12'h000));
    put_tri(0, 0, 1, 2);
    put_vert(0, make_vert(16'h0010, 16'hFFF0, 16'h1234, 12'hF00));
    put_vert(1, make_vert(16'h8000, 16'h7FFF, 16'h0001, 12'h0F0));
    put_vert(2, make_vert(16'hABCD, 16'h0000, 16'hFFFF, 12'h00F));
    run_frame(8'd1, -1);
    check_eq("tri_out.v0", 180'(got_q[0].v0), 180'(vert_m[0]));
    check_eq("tri_out.v1", 180'(got_q[0].v1), 180'(vert_m[1]));
    check_eq("tri_out.v2", 180'(got_q[0].v2), 180'(vert_m[2]));
    check_eq("bg_color", 180'(bg_color), 180'(12'h123));
endtask

task automatic scale_and_wrap();
    // camera at (100, -50, 7)
    put_inst(0, make_inst(0, 0, 0, make_xf(8'h00, 16'd100, 16'hFFCE, 16'd7), 12'h0A5));
    // -1.5 and 3.0 scales
    put_inst(1, make_inst(16, 4, 2, make_xf(8'hE8, 16'hFED4, 16'h8000, 16'hFFFF), 12'h000));
    put_inst(2, make_inst(16, 6, 1, make_xf(8'h30, 16'h7000, 16'h0000, 16'hFFF0), 12'h000));
    put_tri(4, 0, 1, 2);
    put_tri(5, 2, 3, 0);
    put_tri(6, 3, 1, 2);
    put_vert(16, make_vert(16'h7FF0, 16'h8001, 16'h0100, 12'h111));
    put_vert(17, make_vert(16'hFF00, 16'h1234, 16'h8000, 12'h222));
    put_vert(18, make_vert(16'h4000, 16'hC000, 16'h0003, 12'h333));
    put_vert(19, make_vert(16'h0001, 16'hFFFF, 16'h7FFF, 12'h444));
    run_frame(8'd2, -1);
endtask

task automatic load_three_instances();
    put_inst(0, make_inst(0, 0, 0, make_xf(8'h00, 16'hFFF8, 16'd3, 16'd0), 12'h3C3));
    put_inst(1, make_inst(32, 10, 2, make_xf(8'h10, 16'd5, 16'd6, 16'd7), 12'h000));
    put_inst(2, make_inst(32, 12, 0, make_xf(8'h20, 16'd1, 16'd1, 16'd1), 12'h000));
    put_inst(3, make_inst(40, 12, 3, make_xf(8'h08, 16'hFFFF, 16'h0200, 16'h8000), 12'h000));
    put_tri(10, 0, 1, 2);
    put_tri(11, 3, 4, 5);
    put_tri(12, 1, 6, 7);
    put_tri(13, 2, 0, 5);
    put_tri(14, 7, 3, 4);
    for (int k = 0; k < 16; k++) begin
        put_vert(32 + k, make_vert(16'(k * 16'h0911), 16'(16'hF000 - k * 300),
                                   16'(k * k), 12'(k * 12'h111)));
    end
endtask

task automatic instance_order();
    load_three_instances();
    run_frame(8'd3, -1);
    saved_q = got_q;
endtask

task automatic ready_gaps();
    load_three_instances();
    stall_en = 1'b1;
    run_frame(8'd3, -1);
    stall_en     = 1'b0;
    raster_ready = 1'b1;
    check_eq("tri_valid count", 180'(got_q.size()), 180'(saved_q.size()));
    foreach (saved_q[i]) begin
        check_eq("tri_out", got_q[i], saved_q[i]);
    end
endtask

task automatic random_scene();
    int cnt;
    put_inst(0, make_inst(0, 0, 0, make_xf(8'h00, 16'(take_bits(16)), 16'(take_bits(16)),
                                           16'(take_bits(16))), 12'(take_bits(12))));
    for (int i = 1; i <= 4; i++) begin
        cnt = int'(take_bits(2));
        put_inst(i, make_inst(64 + 16 * i, 32 + 4 * i, cnt,
                              make_xf(8'(take_bits(8)), 16'(take_bits(16)),
                                      16'(take_bits(16)), 16'(take_bits(16))), 12'h000));
        for (int k = 0; k < cnt; k++) begin
            put_tri(32 + 4 * i + k, int'(take_bits(4)), int'(take_bits(4)),
                    int'(take_bits(4)));
        end
        for (int k = 0; k < 16; k++) begin
            put_vert(64 + 16 * i + k, make_vert(16'(take_bits(16)), 16'(take_bits(16)),
                                                16'(take_bits(16)), 12'(take_bits(12))));
        end
    end
    run_frame(8'd4, -1);
endtask

task automatic empty_and_restart();
    run_frame(8'd0, -1);
    load_three_instances();
    // second strobe lands mid frame
    run_frame(8'd3, 12);
endtask

//--- sim/tb_render_front.sv
`timescale 1ns/1ps
`default_nettype none

module tb_render_front import geom_pkg::*, scene_pkg::*;;

    localparam int MAX_VERT = 8192;
    localparam int MAX_TRI  = 8192;
    localparam int MAX_INST = 256;

    // a few hundred cycles of table loads per test, under 40 triangles, wide margin
    localparam int CYCLE_LIMIT = 20000;
    localparam int FRAME_LIMIT = 1000;

    logic       clk = 1'b0;
    logic       rst;
    scene_wr_t  scene_wr;
    logic       frame_start;
    logic [7:0] num_inst;
    logic       raster_ready;
    logic       tri_valid;
    triangle_t  tri_out;
    logic       frame_done;
    color12_t   bg_color;
    logic       busy;

    // reference copies of the three tables
    inst_desc_t inst_m [MAX_INST];
    tri_idx_t   tri_m [MAX_TRI];
    vertex_t    vert_m [MAX_VERT];

    triangle_t   exp_q [$];
    triangle_t   got_q [$];
    triangle_t   saved_q [$];
    int          done_cnt = 0;
    int          cycles = 0;
    int          hold = 0;
    logic        stall_en = 1'b0;
    logic [2:0]  rdy_hist = '0;
    logic [31:0] lfsr = 32'h2767;

    render_front #(
        .MAX_VERT (MAX_VERT),
        .MAX_TRI  (MAX_TRI),
        .MAX_INST (MAX_INST)
    ) DUT (
        .clk          (clk),
        .rst          (rst),
        .scene_wr     (scene_wr),
        .frame_start  (frame_start),
        .num_inst     (num_inst),
        .raster_ready (raster_ready),
        .tri_valid    (tri_valid),
        .tri_out      (tri_out),
        .frame_done   (frame_done),
        .bg_color     (bg_color),
        .busy         (busy)
    );

    always #2 clk = ~clk;

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic stop_on_error();
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_eq(input string name, input logic [179:0] got,
                            input logic [179:0] exp);
        assert (got === exp) else begin
            $display("ERR %s got %0h expected %0h", name, got, exp);
            stop_on_error();
        end
    endtask

    // one coordinate, Q4.4 scale then both offsets, wrapped
    function automatic coord_t map_coord(input coord_t p, input logic signed [7:0] s,
                                         input coord_t t, input coord_t c);
        int prod;
        prod = (int'(p) * int'(s)) >>> 4;
        return coord_t'(prod + int'(t) + int'(c));
    endfunction

    function automatic vertex_t apply_transform(input vertex_t v, input transform_t m,
                                                input transform_t cam);
        vertex_t r;
        r.x     = map_coord(v.x, m.scale, m.tx, cam.tx);
        r.y     = map_coord(v.y, m.scale, m.ty, cam.ty);
        r.z     = map_coord(v.z, m.scale, m.tz, cam.tz);
        r.color = v.color;
        return r;
    endfunction

    // triangles in instance order, then table order
    task automatic build_expected(input logic [7:0] n);
        inst_desc_t d;
        tri_idx_t   t;
        triangle_t  tr;
        exp_q.delete();
        for (int i = 1; i <= int'(n); i++) begin
            d = inst_m[i];
            for (int k = 0; k < int'(d.tri_count); k++) begin
                t     = tri_m[13'(d.tri_base + 13'(k))];
                tr.v0 = apply_transform(vert_m[13'(d.vert_base + 13'(t.i0))], d.xf, inst_m[0].xf);
                tr.v1 = apply_transform(vert_m[13'(d.vert_base + 13'(t.i1))], d.xf, inst_m[0].xf);
                tr.v2 = apply_transform(vert_m[13'(d.vert_base + 13'(t.i2))], d.xf, inst_m[0].xf);
                exp_q.push_back(tr);
            end
        end
    endtask

    always @(posedge clk) begin
        rdy_hist <= {rdy_hist[1:0], raster_ready};
    end

    // outputs are settled by the falling edge
    always @(negedge clk) begin
        if (tri_valid) begin
            got_q.push_back(tri_out);
        end
        if (frame_done) begin
            done_cnt++;
        end
        if (tri_valid || frame_done) begin
            assert (rdy_hist[2]) else begin
                $display("output appeared with raster_ready low at its issue cycle");
                stop_on_error();
            end
        end
    end

    // ready gaps of 1 to 8 cycles
    always @(negedge clk) begin
        if (stall_en) begin
            if (hold == 0) begin
                raster_ready = ~raster_ready;
                hold = int'(take_bits(3));
            end else begin
                hold--;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("run stopped after %0d cycles without finishing", cycles);
            stop_on_error();
        end
    end

    `include "tb_tests.svh"

    initial begin
        rst          = 1'b1;
        scene_wr     = '0;
        frame_start  = 1'b0;
        num_inst     = 8'd0;
        raster_ready = 1'b1;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        check_eq("tri_valid", 180'(tri_valid), 180'(0));
        check_eq("frame_done", 180'(frame_done), 180'(0));
        check_eq("busy", 180'(busy), 180'(0));
        check_eq("bg_color", 180'(bg_color), 180'(12'hFFF));

        unity_passthrough();
        scale_and_wrap();
        instance_order();
        ready_gaps();
        random_scene();
        empty_and_restart();

        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- src/render_front.sv
`timescale 1ns/1ps
`default_nettype none

module render_front import geom_pkg::*, scene_pkg::*; #(
    parameter int MAX_VERT = 8192,
    parameter int MAX_TRI  = 8192,
    parameter int MAX_INST = 256
) (
    input  logic       clk,
    input  logic       rst,
    input  scene_wr_t  scene_wr,
    input  logic       frame_start,
    input  logic [7:0] num_inst,
    input  logic       raster_ready,
    output logic       tri_valid,
    output triangle_t  tri_out,
    output logic       frame_done,
    output color12_t   bg_color,
    output logic       busy
);

    localparam int IA_W = $clog2(MAX_INST);
    localparam int TA_W = $clog2(MAX_TRI);
    localparam int VA_W = $clog2(MAX_VERT);

    logic            inst_we;
    logic            tri_we;
    logic            vert_we;
    logic [IA_W-1:0] inst_addr;
    logic [TA_W-1:0] tri_addr;
    logic [VA_W-1:0] vert_addr;
    inst_desc_t      inst_rd;
    tri_idx_t        tri_rd;
    vertex_t         vert_rd;
    logic            lane_valid;
    lane_in_t        lane_in [3];
    transform_t      cam;
    logic [2:0]      lane_ov;
    lane_out_t       lane_out [3];

    assign inst_we = scene_wr.we && (scene_wr.sel == TBL_INST);
    assign tri_we  = scene_wr.we && (scene_wr.sel == TBL_TRI);
    assign vert_we = scene_wr.we && (scene_wr.sel == TBL_VERT);

    scene_ram #(.DEPTH(MAX_INST), .entry_t(inst_desc_t)) u_inst_tbl (
        .clk   (clk),
        .we    (inst_we),
        .waddr (scene_wr.addr[IA_W-1:0]),
        .wdata (scene_wr.data[$bits(inst_desc_t)-1:0]),
        .raddr (inst_addr),
        .rdata (inst_rd)
    );

    scene_ram #(.DEPTH(MAX_TRI), .entry_t(tri_idx_t)) u_tri_tbl (
        .clk   (clk),
        .we    (tri_we),
        .waddr (scene_wr.addr[TA_W-1:0]),
        .wdata (scene_wr.data[$bits(tri_idx_t)-1:0]),
        .raddr (tri_addr),
        .rdata (tri_rd)
    );

    scene_ram #(.DEPTH(MAX_VERT), .entry_t(vertex_t)) u_vert_tbl (
        .clk   (clk),
        .we    (vert_we),
        .waddr (scene_wr.addr[VA_W-1:0]),
        .wdata (scene_wr.data[$bits(vertex_t)-1:0]),
        .raddr (vert_addr),
        .rdata (vert_rd)
    );

    frame_driver #(.MAX_VERT(MAX_VERT), .MAX_TRI(MAX_TRI), .MAX_INST(MAX_INST)) u_driver (
        .clk          (clk),
        .rst          (rst),
        .frame_start  (frame_start),
        .num_inst     (num_inst),
        .raster_ready (raster_ready),
        .inst_addr    (inst_addr),
        .inst_rd      (inst_rd),
        .tri_addr     (tri_addr),
        .tri_rd       (tri_rd),
        .vert_addr    (vert_addr),
        .vert_rd      (vert_rd),
        .lane_valid   (lane_valid),
        .lane_in      (lane_in),
        .cam          (cam),
        .bg_color     (bg_color),
        .busy         (busy),
        .done_seen    (frame_done)
    );

    // one lane per triangle corner
    for (genvar i = 0; i < 3; i++) begin : g_lane
        vertex_xform u_lane (
            .clk       (clk),
            .rst       (rst),
            .in_valid  (lane_valid),
            .in_data   (lane_in[i]),
            .cam       (cam),
            .out_valid (lane_ov[i]),
            .out_data  (lane_out[i])
        );
    end

    tri_assembler u_asm (
        .clk        (clk),
        .rst        (rst),
        .lane_valid (lane_ov),
        .lane_data  (lane_out),
        .tri_valid  (tri_valid),
        .tri_out    (tri_out),
        .frame_done (frame_done)
    );

    // tables are read during the whole frame
    a_host_idle: assert property (@(posedge clk) disable iff (rst) scene_wr.we |-> !busy)
        else $error("scene write to table %0d while busy", scene_wr.sel);

endmodule

`default_nettype wire

//--- src/tri_assembler.sv
`timescale 1ns/1ps
`default_nettype none

module tri_assembler import geom_pkg::*, scene_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic [2:0] lane_valid,
    input  lane_out_t  lane_data [3],
    output logic       tri_valid,
    output triangle_t  tri_out,
    output logic       frame_done
);

    logic is_tri;
    logic is_end;

    // lanes run in lockstep, lane 0 speaks for all
    assign is_tri = lane_valid[0] && !lane_data[0].last;
    assign is_end = lane_valid[0] && lane_data[0].last;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tri_valid  <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            tri_valid  <= is_tri;
            frame_done <= is_end;
        end
    end

    always_ff @(posedge clk) begin
        if (is_tri) begin
            tri_out.v0 <= lane_data[0].vert;
            tri_out.v1 <= lane_data[1].vert;
            tri_out.v2 <= lane_data[2].vert;
        end
    end

    a_lanes_agree: assert property (@(posedge clk) disable iff (rst)
        lane_valid == 3'b000 || lane_valid == 3'b111)
        else $error("lane valids disagree %0h", lane_valid);

    a_end_agree: assert property (@(posedge clk) disable iff (rst)
        lane_valid[0] |-> (lane_data[1].last == lane_data[0].last &&
                           lane_data[2].last == lane_data[0].last))
        else $error("end flag differs between lanes");

endmodule

`default_nettype wire

//--- src/vertex_xform.sv
`timescale 1ns/1ps
`default_nettype none

module vertex_xform import geom_pkg::*, scene_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       in_valid,
    input  lane_in_t   in_data,
    input  transform_t cam,
    output logic       out_valid,
    output lane_out_t  out_data
);

    localparam int PROD_W = 24;

    logic                     s1_valid;
    logic signed [PROD_W-1:0] s1_px;
    logic signed [PROD_W-1:0] s1_py;
    logic signed [PROD_W-1:0] s1_pz;
    coord_t                   s1_tx;
    coord_t                   s1_ty;
    coord_t                   s1_tz;
    color12_t                 s1_color;
    logic                     s1_last;

    // drop the fraction, add both offsets, wrap to 16 bits
    function automatic coord_t place(input logic signed [PROD_W-1:0] prod,
                                     input coord_t model_t, input coord_t cam_t);
        logic signed [PROD_W-1:0] sum;
        sum = (prod >>> SCALE_FRAC) + model_t + cam_t;
        return sum[15:0];
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            s1_valid  <= in_valid;
            out_valid <= s1_valid;
        end
    end

    // stage 1 products
    always_ff @(posedge clk) begin
        s1_px    <= in_data.vert.x * in_data.xf.scale;
        s1_py    <= in_data.vert.y * in_data.xf.scale;
        s1_pz    <= in_data.vert.z * in_data.xf.scale;
        s1_tx    <= in_data.xf.tx;
        s1_ty    <= in_data.xf.ty;
        s1_tz    <= in_data.xf.tz;
        s1_color <= in_data.vert.color;
        s1_last  <= in_data.last;
    end

    // stage 2 translate
    always_ff @(posedge clk) begin
        out_data.vert.x     <= place(s1_px, s1_tx, cam.tx);
        out_data.vert.y     <= place(s1_py, s1_ty, cam.ty);
        out_data.vert.z     <= place(s1_pz, s1_tz, cam.tz);
        out_data.vert.color <= s1_color;
        out_data.last       <= s1_last;
    end

endmodule

`default_nettype wire

//--- src/frame_driver.sv
`timescale 1ns/1ps
`default_nettype none

module frame_driver import geom_pkg::*, scene_pkg::*; #(
    parameter int MAX_VERT = 8192,
    parameter int MAX_TRI  = 8192,
    parameter int MAX_INST = 256
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        frame_start,
    input  logic [7:0]                  num_inst,
    input  logic                        raster_ready,
    output logic [$clog2(MAX_INST)-1:0] inst_addr,
    input  inst_desc_t                  inst_rd,
    output logic [$clog2(MAX_TRI)-1:0]  tri_addr,
    input  tri_idx_t                    tri_rd,
    output logic [$clog2(MAX_VERT)-1:0] vert_addr,
    input  vertex_t                     vert_rd,
    output logic                        lane_valid,
    output lane_in_t                    lane_in [3],
    output transform_t                  cam,
    output color12_t                    bg_color,
    output logic                        busy,
    input  logic                        done_seen
);

    localparam int IA_W = $clog2(MAX_INST);
    localparam int TA_W = $clog2(MAX_TRI);
    localparam int VA_W = $clog2(MAX_VERT);

    typedef enum logic [3:0] {
        S_IDLE,
        S_CAM_RD,
        S_CAM_CAP,
        S_INST_RD,
        S_INST_CAP,
        S_TRI_RD,
        S_TRI_CAP,
        S_V0_REQ,
        S_V0_CAP,
        S_V1_CAP,
        S_V2_CAP,
        S_ISSUE,
        S_END,
        S_WAIT
    } state_t;

    state_t      state;
    logic [7:0]  num_inst_r;
    logic [7:0]  inst_cnt;
    logic [7:0]  tri_left;
    logic [12:0] vert_base_r;
    transform_t  xf_r;
    tri_idx_t    idx_r;
    vertex_t     vtx_r [3];
    logic        start_ok;
    logic        last_inst;

    function automatic logic [VA_W-1:0] vaddr(input logic [12:0] base, input logic [7:0] idx);
        return VA_W'(base + 13'(idx));
    endfunction

    assign start_ok   = frame_start && !busy;
    assign last_inst  = (inst_cnt == num_inst_r);
    assign lane_valid = (state == S_ISSUE || state == S_END) && raster_ready;
    // drops together with frame_done
    assign busy       = (state != S_IDLE) && !(state == S_WAIT && done_seen);
    assign inst_addr  = IA_W'(inst_cnt);

    always_comb begin
        for (int i = 0; i < 3; i++) begin
            lane_in[i].vert = vtx_r[i];
            lane_in[i].xf   = xf_r;
            lane_in[i].last = (state == S_END);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= S_IDLE;
            num_inst_r <= '0;
            inst_cnt   <= '0;
            tri_left   <= '0;
            tri_addr   <= '0;
            vert_addr  <= '0;
            cam        <= '0;
            bg_color   <= BG_DEFAULT;
        end else if (start_ok) begin
            state      <= S_CAM_RD;
            num_inst_r <= num_inst;
            inst_cnt   <= '0;
        end else begin
            case (state)
                S_CAM_RD: state <= S_CAM_CAP;
                S_CAM_CAP: begin
                    cam      <= inst_rd.xf;
                    bg_color <= inst_rd.color;
                    if (last_inst) begin
                        state <= S_END;
                    end else begin
                        inst_cnt <= inst_cnt + 8'd1;
                        state    <= S_INST_RD;
                    end
                end
                S_INST_RD: state <= S_INST_CAP;
                S_INST_CAP: begin
                    tri_left <= inst_rd.tri_count;
                    tri_addr <= TA_W'(inst_rd.tri_base);
                    // empty instances are skipped
                    if (inst_rd.tri_count != 8'd0) begin
                        state <= S_TRI_RD;
                    end else if (last_inst) begin
                        state <= S_END;
                    end else begin
                        inst_cnt <= inst_cnt + 8'd1;
                        state    <= S_INST_RD;
                    end
                end
                S_TRI_RD: state <= S_TRI_CAP;
                S_TRI_CAP: begin
                    vert_addr <= vaddr(vert_base_r, tri_rd.i0);
                    state     <= S_V0_REQ;
                end
                S_V0_REQ: begin
                    vert_addr <= vaddr(vert_base_r, idx_r.i1);
                    state     <= S_V0_CAP;
                end
                S_V0_CAP: begin
                    vert_addr <= vaddr(vert_base_r, idx_r.i2);
                    state     <= S_V1_CAP;
                end
                S_V1_CAP: state <= S_V2_CAP;
                S_V2_CAP: state <= S_ISSUE;
                S_ISSUE: begin
                    if (raster_ready) begin
                        if (tri_left != 8'd1) begin
                            tri_left <= tri_left - 8'd1;
                            tri_addr <= tri_addr + 1'b1;
                            state    <= S_TRI_RD;
                        end else if (last_inst) begin
                            state <= S_END;
                        end else begin
                            inst_cnt <= inst_cnt + 8'd1;
                            state    <= S_INST_RD;
                        end
                    end
                end
                S_END: begin
                    if (raster_ready) begin
                        state <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    if (done_seen) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            S_INST_CAP: begin
                vert_base_r <= inst_rd.vert_base;
                xf_r        <= inst_rd.xf;
            end
            S_TRI_CAP: idx_r <= tri_rd;
            S_V0_CAP: vtx_r[0] <= vert_rd;
            S_V1_CAP: vtx_r[1] <= vert_rd;
            S_V2_CAP: vtx_r[2] <= vert_rd;
            default: ;
        endcase
    end

    // a held triangle or end token waits in place for raster_ready
    a_issue_gate: assert property (@(posedge clk) disable iff (rst)
        (state == S_ISSUE || state == S_END) && !raster_ready |=> state == $past(state))
        else $error("issue left its state while raster_ready low");

    a_inst_range: assert property (@(posedge clk) disable iff (rst)
        start_ok |-> num_inst < MAX_INST)
        else $error("num_inst %0h beyond instance table", num_inst);

    // frame_done only answers an end token already sent
    a_done_wait: assert property (@(posedge clk) disable iff (rst) done_seen |-> state == S_WAIT)
        else $error("frame_done seen in state %0d", state);

endmodule

`default_nettype wire

//--- src/scene_ram.sv
`timescale 1ns/1ps
`default_nettype none

module scene_ram #(
    parameter int  DEPTH   = 256,
    parameter type entry_t = logic [7:0]
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  entry_t                   wdata,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    output entry_t                   rdata
);

    entry_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // data one cycle after the address edge
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

    a_waddr_range: assert property (@(posedge clk) we |-> waddr < DEPTH)
        else $error("scene_ram write address %0h beyond depth %0d", waddr, DEPTH);

    a_raddr_range: assert property (@(posedge clk) raddr < DEPTH)
        else $error("scene_ram read address %0h beyond depth %0d", raddr, DEPTH);

endmodule

`default_nettype wire

//--- src/scene_pkg.sv
`default_nettype none

package scene_pkg;

    import geom_pkg::*;

    localparam int TBL_ADDR_W = 13;
    localparam int TBL_DATA_W = 128;

    typedef enum logic [1:0] {
        TBL_INST,
        TBL_TRI,
        TBL_VERT
    } table_sel_t;

    // each table takes the low bits of data
    typedef struct packed {
        logic                  we;
        table_sel_t            sel;
        logic [TBL_ADDR_W-1:0] addr;
        logic [TBL_DATA_W-1:0] data;
    } scene_wr_t;

    // indices relative to the instance vertex base
    typedef struct packed {
        logic [7:0] i0;
        logic [7:0] i1;
        logic [7:0] i2;
    } tri_idx_t;

    // instance 0 uses only xf translation and color
    typedef struct packed {
        logic [12:0] vert_base;
        logic [12:0] tri_base;
        logic [7:0]  tri_count;
        transform_t  xf;
        color12_t    color;
    } inst_desc_t;

    typedef struct packed {
        vertex_t    vert;
        transform_t xf;
        logic       last;
    } lane_in_t;

    typedef struct packed {
        vertex_t vert;
        logic    last;
    } lane_out_t;

endpackage

`default_nettype wire

//--- src/geom_pkg.sv
`default_nettype none

package geom_pkg;

    // fractional bits of the model scale
    localparam int SCALE_FRAC = 4;

    // clear colour until instance 0 has been read
    localparam logic [11:0] BG_DEFAULT = 12'hFFF;

    typedef logic signed [15:0] coord_t;

    // 4 bits each of r, g, b
    typedef logic [11:0] color12_t;

    typedef struct packed {
        coord_t   x;
        coord_t   y;
        coord_t   z;
        color12_t color;
    } vertex_t;

    // Q4.4 scale, 16 is unity
    typedef struct packed {
        logic signed [7:0] scale;
        coord_t            tx;
        coord_t            ty;
        coord_t            tz;
    } transform_t;

    typedef struct packed {
        vertex_t v0;
        vertex_t v1;
        vertex_t v2;
    } triangle_t;

endpackage

`default_nettype wire
